// ==== files.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

// ==== bench/dcache_tb.sv ====
// data cache testbench with clock, reset, directed tests, value check and verdict
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;

	import dcache_pkg::*;

	localparam int TIMEOUT = 40;

	logic                  clk;
	logic                  proc_reset;
	dc_proc_req_t          proc_req;
	logic [`DC_WORD_W-1:0] proc_rdata;
	logic                  proc_stall;
	dc_mem_req_t           mem_req;
	logic [`DC_LINE_W-1:0] mem_rdata;
	logic                  mem_ready;

	// bookkeeping and expected memory contents
	int                    errors;
	int                    checks;
	logic [`DC_LINE_W-1:0] mirror [64];
	logic [`DC_LINE_W-1:0] merged_line;
	event                  abort_ev;

	dcache_top dut_i (.*);
	dcache_mem_model mem_i (.*);

	always #50 clk = ~clk;

	// word address from tag, set and word offset
	function automatic logic [`DC_ADDR_W-1:0] word_addr(input logic [`DC_TAG_W-1:0] tag,
		input logic [`DC_SET_W-1:0] set, input logic [`DC_OFS_W-1:0] ofs);
		return {tag, set, ofs};
	endfunction

	function automatic logic [`DC_WORD_W-1:0] word_of(input logic [`DC_LINE_W-1:0] line,
		input int ofs);
		return line[ofs*`DC_WORD_W +: `DC_WORD_W];
	endfunction

	task automatic check(input string name, input logic [`DC_LINE_W-1:0] exp,
		input logic [`DC_LINE_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	// ------------------------------------------------------------------------
	// one processor access held until stall drops
	// ------------------------------------------------------------------------
	task automatic access(input logic wr, input logic [`DC_ADDR_W-1:0] addr,
		input logic [`DC_WORD_W-1:0] wdata, output logic [`DC_WORD_W-1:0] rdata,
		output logic stalled);
		dc_proc_req_t req;
		int           cycles;
		req.read  = !wr;
		req.write = wr;
		req.addr  = addr;
		req.wdata = wdata;
		stalled   = 1'b0;
		cycles    = 0;
		@(posedge clk);
		proc_req <= req;
		// sample mid-cycle once outputs settle
		@(negedge clk);
		while (proc_stall && cycles < TIMEOUT) begin
			stalled = 1'b1;
			@(negedge clk);
			cycles++;
		end
		if (proc_stall) begin
			$display("Timeout: access to word address %0h still stalled after %0d cycles",
				addr, TIMEOUT);
			errors++;
			-> abort_ev;
		end
		rdata = proc_rdata;
		@(posedge clk);
		proc_req <= '0;
	endtask

	task automatic read_word(input string name, input logic [`DC_ADDR_W-1:0] addr,
		input logic [`DC_WORD_W-1:0] exp, input logic exp_stall);
		logic [`DC_WORD_W-1:0] data;
		logic                  stalled;
		access(1'b0, addr, '0, data, stalled);
		check({name, " data"}, exp, data);
		check({name, " stall"}, exp_stall, stalled);
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset();
		@(negedge clk);
		check("reset stall", 1'b0, proc_stall);
		check("reset mem read", 1'b0, mem_req.read);
		check("reset mem write", 1'b0, mem_req.write);
	endtask

	task automatic test_cold_miss();
		logic [`DC_ADDR_W-1:0] addr;
		int                    reads;
		// tag 0 in set 1 is line address 1
		addr  = word_addr(0, 1, 2);
		reads = mem_i.rd_count;
		read_word("cold miss", addr, word_of(mirror[1], 2), 1'b1);
		check("cold miss mem reads", reads + 1, mem_i.rd_count);
		check("cold miss line address", 28'd1, mem_i.last_rd_addr);
	endtask

	task automatic test_read_hit();
		int reads;
		int writes;
		reads  = mem_i.rd_count;
		writes = mem_i.wr_count;
		for (int ofs = 0; ofs < 4; ofs++) begin
			read_word($sformatf("read hit word %0d", ofs), word_addr(0, 1, ofs),
				word_of(mirror[4'd1], ofs), 1'b0);
		end
		check("read hit mem reads", reads, mem_i.rd_count);
		check("read hit mem writes", writes, mem_i.wr_count);
	endtask

	task automatic test_write_hit();
		logic [`DC_WORD_W-1:0] data;
		logic                  stalled;
		int                    reads;
		int                    writes;
		reads  = mem_i.rd_count;
		writes = mem_i.wr_count;
		// word 1 of tag 0 in set 1 gets a known pattern
		merged_line        = mirror[1];
		merged_line[63:32] = 32'h5a5a_c3c3;
		access(1'b1, word_addr(0, 1, 1), 32'h5a5a_c3c3, data, stalled);
		check("write hit stall", 1'b0, stalled);
		for (int ofs = 0; ofs < 4; ofs++) begin
			read_word($sformatf("write hit word %0d", ofs), word_addr(0, 1, ofs),
				word_of(merged_line, ofs), 1'b0);
		end
		check("write hit mem reads", reads, mem_i.rd_count);
		check("write hit mem writes", writes, mem_i.wr_count);
	endtask

	task automatic test_clean_evict();
		int writes;
		writes = mem_i.wr_count;
		// tags 0 and 1 fill both ways of set 2 and tag 2 evicts way 0
		read_word("clean fill way 0", word_addr(0, 2, 0), word_of(mirror[2], 0), 1'b1);
		read_word("clean fill way 1", word_addr(1, 2, 3), word_of(mirror[6], 3), 1'b1);
		read_word("clean evict", word_addr(2, 2, 1), word_of(mirror[10], 1), 1'b1);
		// tag 1 survived the eviction
		read_word("clean survivor", word_addr(1, 2, 0), word_of(mirror[6], 0), 1'b0);
		check("clean evict mem writes", writes, mem_i.wr_count);
	endtask

	task automatic test_dirty_evict();
		int writes;
		writes = mem_i.wr_count;
		// victim pointer of set 1 sits at way 1 so tag 1 fills and tag 2 evicts dirty tag 0
		read_word("dirty fill way 1", word_addr(1, 1, 0), word_of(mirror[5], 0), 1'b1);
		read_word("dirty evict", word_addr(2, 1, 2), word_of(mirror[9], 2), 1'b1);
		check("dirty evict mem writes", writes + 1, mem_i.wr_count);
		check("dirty evict line address", 28'd1, mem_i.last_wr_addr);
		check("dirty evict line data", merged_line, mem_i.last_wr_data);
		mirror[1] = merged_line;
		// written word comes back from memory
		read_word("dirty reread", word_addr(0, 1, 1), word_of(mirror[1], 1), 1'b1);
		check("dirty reread mem writes", writes + 1, mem_i.wr_count);
	endtask

	// timeout path ends the run here
	initial begin
		@(abort_ev);
		$display("dcache_tb: %0d checks, %0d errors", checks, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		clk        = 1'b0;
		proc_reset = 1'b1;
		proc_req   = '0;
		errors     = 0;
		checks     = 0;
		// mirror after the model has filled its store
		#1;
		for (int a = 0; a < 64; a++) begin
			mirror[a] = mem_i.mem[a];
		end
		repeat (3) @(posedge clk);
		proc_reset <= 1'b0;
		test_reset();
		test_cold_miss();
		test_read_hit();
		test_write_hit();
		test_clean_evict();
		test_dirty_evict();
		$display("dcache_tb: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== bench/dcache_mem_model.sv ====
// line-wide backing memory with fixed ready latency, random contents and a request log
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_mem_model (
	input  logic                     clk,
	input  logic                     proc_reset,
	input  dcache_pkg::dc_mem_req_t  mem_req,
	output logic [`DC_LINE_W-1:0]    mem_rdata = '0,
	output logic                     mem_ready = 1'b0
);

	localparam int MEM_LINES = 64;

	// backing store, low line-address bits pick the entry
	logic [`DC_LINE_W-1:0] mem [MEM_LINES];

	// request log, read by the bench
	int                     rd_count;
	int                     wr_count;
	logic [`DC_LADDR_W-1:0] last_rd_addr;
	logic [`DC_LADDR_W-1:0] last_wr_addr;
	logic [`DC_LINE_W-1:0]  last_wr_data;

	int         seed;
	int         wait_cnt;
	logic [5:0] idx;

	assign idx = mem_req.addr[5:0];

	// random contents, four draws per line
	initial begin
		seed = 14;
		for (int a = 0; a < MEM_LINES; a++) begin
			mem[a] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
	end

	// ------------------------------------------------------------------------
	// request handling, ready three cycles after the request shows up
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			mem_ready <= 1'b0;
			wait_cnt  <= 0;
			rd_count  <= 0;
			wr_count  <= 0;
		end else begin
			// single-cycle pulse
			mem_ready <= 1'b0;
			if ((mem_req.read || mem_req.write) && !mem_ready) begin
				if (wait_cnt == 2) begin
					mem_ready <= 1'b1;
					wait_cnt  <= 0;
					if (mem_req.write) begin
						mem[idx]     <= mem_req.wdata;
						wr_count     <= wr_count + 1;
						last_wr_addr <= mem_req.addr;
						last_wr_data <= mem_req.wdata;
					end else begin
						// line valid together with ready
						mem_rdata    <= mem[idx];
						rd_count     <= rd_count + 1;
						last_rd_addr <= mem_req.addr;
					end
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule

// ==== rtl/dcache_top.sv ====
// data cache top level joining controller, tag array and data array
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
	input  logic                      clk,
	input  logic                      proc_reset,
	input  dcache_pkg::dc_proc_req_t  proc_req,
	output logic [`DC_WORD_W-1:0]     proc_rdata,
	output logic                      proc_stall,
	output dcache_pkg::dc_mem_req_t   mem_req,
	input  logic [`DC_LINE_W-1:0]     mem_rdata,
	input  logic                      mem_ready
);

	// lookup results from the tag array
	logic                 hit;
	logic                 hit_way;
	logic                 victim_way;
	logic                 victim_dirty;
	logic [`DC_TAG_W-1:0] victim_tag;

	// victim data for write-back
	logic [`DC_LINE_W-1:0] victim_line;

	// update strobes from the controller
	logic word_we;
	logic fill_we;

	// ------------------------------------------------------------------------
	// miss FSM
	// ------------------------------------------------------------------------
	dcache_ctrl ctrl_i (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.mem_req      (mem_req),
		.word_we      (word_we),
		.fill_we      (fill_we)
	);

	// tags, valid, dirty and victim pointer
	dcache_tag_array tag_i (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.word_we      (word_we),
		.fill_we      (fill_we),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	// line storage, read word goes straight out
	dcache_data_array data_i (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.word_we      (word_we),
		.fill_we      (fill_we),
		.mem_rdata    (mem_rdata),
		.rdata        (proc_rdata),
		.victim_line  (victim_line)
	);

endmodule

// ==== rtl/dcache_ctrl.sv ====
// miss-handling FSM driving stall, memory requests and array update strobes
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl (
	input  logic                      clk,
	input  logic                      proc_reset,
	input  dcache_pkg::dc_proc_req_t  proc_req,
	input  logic                      hit,
	input  logic                      victim_dirty,
	input  logic [`DC_TAG_W-1:0]      victim_tag,
	input  logic [`DC_LINE_W-1:0]     victim_line,
	input  logic                      mem_ready,
	output logic                      proc_stall,
	output dcache_pkg::dc_mem_req_t   mem_req,
	output logic                      word_we,
	output logic                      fill_we
);

	import dcache_pkg::*;

	dc_state_t state;
	dc_state_t state_nxt;

	// request decode
	logic                 req_valid;
	logic                 miss;
	logic [`DC_SET_W-1:0] set_idx;

	assign req_valid = proc_req.read | proc_req.write;
	assign miss      = req_valid & ~hit;
	assign set_idx   = proc_req.addr[`DC_OFS_W +: `DC_SET_W];

	// ------------------------------------------------------------------------
	// next state and outputs
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt  = state;
		proc_stall = 1'b0;
		mem_req    = '0;
		word_we    = 1'b0;
		fill_we    = 1'b0;

		case (state)
			ST_COMPARE: begin
				// stall in the same cycle as the miss
				proc_stall = miss;
				// write hit updates the word at the next edge
				word_we    = proc_req.write & hit;
				if (miss) begin
					// dirty victim must go out first
					state_nxt = victim_dirty ? ST_WRITE_BACK : ST_ALLOCATE;
				end
			end

			ST_WRITE_BACK: begin
				proc_stall    = 1'b1;
				mem_req.write = 1'b1;
				// victim line address rebuilt from its tag and this set
				mem_req.addr  = {victim_tag, set_idx};
				mem_req.wdata = victim_line;
				if (mem_ready) begin
					state_nxt = ST_ALLOCATE;
				end
			end

			ST_ALLOCATE: begin
				proc_stall   = 1'b1;
				mem_req.read = 1'b1;
				// line address of the pending request
				mem_req.addr = proc_req.addr[`DC_ADDR_W-1:`DC_OFS_W];
				if (mem_ready) begin
					// line valid on mem_rdata this cycle
					fill_we   = 1'b1;
					state_nxt = ST_COMPARE;
				end
			end

			default: begin
				state_nxt = ST_COMPARE;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// state register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= ST_COMPARE;
		end else begin
			state <= state_nxt;
		end
	end

	// one memory direction at a time
	a_mem_rw_excl : assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
		else $error("dcache ctrl: memory read and write together");

	// fill only on a completed read, then back to compare
	a_fill_on_ready : assert property (@(posedge clk) disable iff (proc_reset)
		fill_we |-> (mem_ready && mem_req.read) ##1 (state == ST_COMPARE))
		else $error("dcache ctrl: line fill without memory ready");

endmodule

// ==== rtl/dcache_data_array.sv ====
// data array with line storage per way, word read select, write-hit merge and line fill
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_data_array (
	input  logic                      clk,
	input  logic                      proc_reset,
	input  dcache_pkg::dc_proc_req_t  proc_req,
	input  logic                      hit_way,
	input  logic                      victim_way,
	input  logic                      word_we,
	input  logic                      fill_we,
	input  logic [`DC_LINE_W-1:0]     mem_rdata,
	output logic [`DC_WORD_W-1:0]     rdata,
	output logic [`DC_LINE_W-1:0]     victim_line
);

	// line seen as words, word 0 in the low bits
	typedef logic [`DC_LINE_W/`DC_WORD_W-1:0][`DC_WORD_W-1:0] line_t;

	// request fields
	logic [`DC_SET_W-1:0] set_idx;
	logic [`DC_OFS_W-1:0] ofs;

	// line storage
	line_t lines [2][`DC_SETS];

	assign set_idx = proc_req.addr[`DC_OFS_W +: `DC_SET_W];
	assign ofs     = proc_req.addr[`DC_OFS_W-1:0];

	// ------------------------------------------------------------------------
	// read side
	// ------------------------------------------------------------------------
	// addressed word of the hit way
	assign rdata = lines[hit_way][set_idx][ofs];

	// whole victim line for write-back
	assign victim_line = lines[victim_way][set_idx];

	// ------------------------------------------------------------------------
	// write side, one edge
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		// no array writes while reset is held
		if (!proc_reset) begin
			if (word_we) begin
				// merge the new word, rest of the line untouched
				lines[hit_way][set_idx][ofs] <= proc_req.wdata;
			end
			if (fill_we) begin
				// refill replaces the victim line
				lines[victim_way][set_idx] <= mem_rdata;
			end
		end
	end

endmodule

// ==== rtl/dcache_tag_array.sv ====
// tag array with valid, dirty and tag per way, victim pointer per set, hit detection
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tag_array (
	input  logic                      clk,
	input  logic                      proc_reset,
	input  dcache_pkg::dc_proc_req_t  proc_req,
	input  logic                      word_we,
	input  logic                      fill_we,
	output logic                      hit,
	output logic                      hit_way,
	output logic                      victim_way,
	output logic                      victim_dirty,
	output logic [`DC_TAG_W-1:0]      victim_tag
);

	// address fields of the current request
	logic [`DC_SET_W-1:0] set_idx;
	logic [`DC_TAG_W-1:0] req_tag;

	// state bits, way major
	logic [1:0][`DC_SETS-1:0] valid;
	logic [1:0][`DC_SETS-1:0] dirty;
	logic [`DC_SETS-1:0]      victim;

	// tag storage
	logic [`DC_TAG_W-1:0] tags [2][`DC_SETS];

	// per-way match
	logic [1:0] way_hit;

	assign set_idx = proc_req.addr[`DC_OFS_W +: `DC_SET_W];
	assign req_tag = proc_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

	// ------------------------------------------------------------------------
	// lookup, zero latency
	// ------------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			// invalid ways never match, whatever the tag holds
			way_hit[w] = valid[w][set_idx] && (tags[w][set_idx] == req_tag);
		end
	end

	assign hit     = |way_hit;
	// way 1 index doubles as the way number
	assign hit_way = way_hit[1];

	// victim side for write-back and refill
	assign victim_way   = victim[set_idx];
	assign victim_dirty = valid[victim_way][set_idx] & dirty[victim_way][set_idx];
	assign victim_tag   = tags[victim_way][set_idx];

	// ------------------------------------------------------------------------
	// state update
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			// all lines invalid and clean, way 0 first to fill
			valid  <= '0;
			dirty  <= '0;
			victim <= '0;
		end else begin
			// write hit marks the line modified
			if (word_we) begin
				dirty[hit_way][set_idx] <= 1'b1;
			end
			// refill lands clean in the victim way
			if (fill_we) begin
				valid[victim_way][set_idx] <= 1'b1;
				dirty[victim_way][set_idx] <= 1'b0;
				// round robin over two ways
				victim[set_idx] <= ~victim[set_idx];
			end
		end
	end

	// tag written on refill only
	always_ff @(posedge clk) begin
		if (fill_we) begin
			tags[victim_way][set_idx] <= req_tag;
		end
	end

	// a refill only ever happens after a miss, so one line per tag and set
	a_single_way_hit : assert property (@(posedge clk) disable iff (proc_reset)
		!(&way_hit))
		else $error("tag array: both ways hit in set %0d", set_idx);

endmodule

// ==== rtl/dcache_pkg.sv ====
// controller state enum and processor / memory request structs for the data cache
`include "dcache_defines.svh"

package dcache_pkg;

	// ------------------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------------------
	// compare-tag is also the state out of reset
	typedef enum logic [1:0] {
		ST_COMPARE    = 2'd0,
		ST_WRITE_BACK = 2'd1,
		ST_ALLOCATE   = 2'd2
	} dc_state_t;

	// ------------------------------------------------------------------------
	// request structs
	// ------------------------------------------------------------------------
	// processor request, held stable while stalled
	typedef struct packed {
		logic                  read;
		logic                  write;
		logic [`DC_ADDR_W-1:0] addr;
		logic [`DC_WORD_W-1:0] wdata;
	} dc_proc_req_t;

	// memory request, line granular
	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [`DC_LADDR_W-1:0] addr;
		logic [`DC_LINE_W-1:0]  wdata;
	} dc_mem_req_t;

endpackage

// ==== rtl/dcache_defines.svh ====
// width and size macros for the data cache
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// processor side, one 32-bit word per access
`define DC_WORD_W   32
`define DC_ADDR_W   30

// memory side, whole lines only
`define DC_LINE_W   128
`define DC_LADDR_W  28

// word address split, top down: tag | set | offset
`define DC_OFS_W    2
`define DC_SET_W    2
`define DC_TAG_W    26

// two ways of this many sets
`define DC_SETS     4

`endif
